// File: hdl/rd_xbar_pkg.sv
// Shared counts, widths, channel structs and codes for the read crossbar, used by scoped name
`default_nettype none

package rd_xbar_pkg;

  // Port counts
  localparam int unsigned NUM_REQ = 2;
  localparam int unsigned NUM_TGT = 2;

  // Field widths
  localparam int unsigned ADDR_W    = 32;
  localparam int unsigned DATA_W    = 32;
  localparam int unsigned REQ_ID_W  = 4;
  localparam int unsigned REQ_IDX_W = 1;
  localparam int unsigned TGT_ID_W  = REQ_ID_W + REQ_IDX_W;
  localparam int unsigned LEN_W     = 4;
  localparam int unsigned TGT_IDX_W = 1;

  // Destination index, one more than the targets for the error lane
  localparam int unsigned DST_W = 2;
  localparam logic [DST_W-1:0] DST_ERR = DST_W'(NUM_TGT);

  // Response codes
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'd0,
    RESP_DECERR = 2'd3
  } resp_e;

  // Requester side, narrow ID
  typedef struct packed {
    logic [REQ_ID_W-1:0] id;
    logic [ADDR_W-1:0]   addr;
    logic [LEN_W-1:0]    len;
  } req_ar_t;

  typedef struct packed {
    logic [REQ_ID_W-1:0] id;
    logic [DATA_W-1:0]   data;
    resp_e               resp;
    logic                last;
  } req_r_t;

  // Target side, requester index on top of the ID
  typedef struct packed {
    logic [TGT_ID_W-1:0] id;
    logic [ADDR_W-1:0]   addr;
    logic [LEN_W-1:0]    len;
  } tgt_ar_t;

  typedef struct packed {
    logic [TGT_ID_W-1:0] id;
    logic [DATA_W-1:0]   data;
    resp_e               resp;
    logic                last;
  } tgt_r_t;

  // Address rule, start included and end excluded
  typedef struct packed {
    logic [TGT_IDX_W-1:0] tgt_idx;
    logic [ADDR_W-1:0]    start_addr;
    logic [ADDR_W-1:0]    end_addr;
  } rule_t;

endpackage

`default_nettype wire

// File: hdl/rd_addr_decoder.sv
// Combinational address decoder, maps a read address to a target lane or the error lane
`timescale 1ns/1ps
`default_nettype none

module rd_addr_decoder #(
  parameter int unsigned NumRules = 3
) (
  input  logic [rd_xbar_pkg::ADDR_W-1:0]    addr_i,
  input  rd_xbar_pkg::rule_t [NumRules-1:0] addr_map_i,
  input  logic                              dflt_en_i,
  input  logic [rd_xbar_pkg::TGT_IDX_W-1:0] dflt_tgt_i,
  output logic [rd_xbar_pkg::DST_W-1:0]     dst_o
);

  // Any rule hit and the target of the last one that hit
  logic                              hit;
  logic [rd_xbar_pkg::TGT_IDX_W-1:0] hit_idx;

  // Walk all rules upward
  // A later match overwrites an earlier one, so the highest index wins
  always_comb begin
    hit     = 1'b0;
    hit_idx = '0;
    for (int r = 0; r < NumRules; r++) begin
      if ((addr_map_i[r].start_addr <= addr_i) &&
          (addr_i < addr_map_i[r].end_addr)) begin
        hit     = 1'b1;
        hit_idx = addr_map_i[r].tgt_idx;
      end
    end
  end

  // Pick the lane
  // Miss falls back to the default target, or to the error lane when that is off
  always_comb begin
    dst_o = '0;
    if (hit) begin
      dst_o[rd_xbar_pkg::TGT_IDX_W-1:0] = hit_idx;
    end else if (dflt_en_i) begin
      dst_o[rd_xbar_pkg::TGT_IDX_W-1:0] = dflt_tgt_i;
    end else begin
      dst_o = rd_xbar_pkg::DST_ERR;
    end
  end

endmodule

`default_nettype wire

// File: hdl/rd_req_demux.sv
// Per-requester demux, steers AR to one lane under the ordering rule and merges R back
`timescale 1ns/1ps
`default_nettype none

module rd_req_demux #(
  parameter int unsigned MaxTrans = 4
) (
  input  logic                                              clk_i,
  input  logic                                              arst_n_i,
  // Requester AR
  input  rd_xbar_pkg::req_ar_t                              ar_i,
  input  logic                                              ar_valid_i,
  output logic                                              ar_ready_o,
  input  logic [rd_xbar_pkg::DST_W-1:0]                     dst_i,
  // Requester R
  output rd_xbar_pkg::req_r_t                               r_o,
  output logic                                              r_valid_o,
  input  logic                                              r_ready_i,
  // Destination lanes, the last one is the error responder
  output rd_xbar_pkg::req_ar_t [rd_xbar_pkg::NUM_TGT:0]     lane_ar_o,
  output logic [rd_xbar_pkg::NUM_TGT:0]                     lane_ar_valid_o,
  input  logic [rd_xbar_pkg::NUM_TGT:0]                     lane_ar_ready_i,
  input  rd_xbar_pkg::req_r_t [rd_xbar_pkg::NUM_TGT:0]      lane_r_i,
  input  logic [rd_xbar_pkg::NUM_TGT:0]                     lane_r_valid_i,
  output logic [rd_xbar_pkg::NUM_TGT:0]                     lane_r_ready_o
);

  localparam int unsigned CntW = $clog2(MaxTrans + 1);

  typedef enum logic {
    ST_IDLE = 1'b0,
    ST_BUSY = 1'b1
  } state_e;

  state_e                         state_q;
  logic [rd_xbar_pkg::DST_W-1:0] dst_q;
  logic [CntW-1:0]               cnt_q;

  logic allow;
  logic dst_ready;
  logic ar_fire;
  logic r_done;

  // Ordering rule
  // Room left, and either nothing in flight or the same lane as before
  assign allow = (cnt_q < MaxTrans) && ((state_q == ST_IDLE) || (dst_i == dst_q));

  // AR steering, payload goes to every lane and only one valid rises
  always_comb begin
    dst_ready = 1'b0;
    for (int k = 0; k <= rd_xbar_pkg::NUM_TGT; k++) begin
      lane_ar_o[k]       = ar_i;
      lane_ar_valid_o[k] = ar_valid_i && allow && (dst_i == k);
      if (dst_i == k) begin
        dst_ready = lane_ar_ready_i[k];
      end
    end
  end

  assign ar_ready_o = allow && dst_ready;
  assign ar_fire    = ar_valid_i && ar_ready_o;

  // R merge
  // Only the stored lane can hold answers while reads are in flight
  always_comb begin
    r_o       = lane_r_i[0];
    r_valid_o = 1'b0;
    for (int k = 0; k <= rd_xbar_pkg::NUM_TGT; k++) begin
      lane_r_ready_o[k] = r_ready_i && (state_q == ST_BUSY) && (dst_q == k);
      if (dst_q == k) begin
        r_o       = lane_r_i[k];
        r_valid_o = lane_r_valid_i[k] && (state_q == ST_BUSY);
      end
    end
  end

  // A burst finishes with its last beat
  assign r_done = r_valid_o && r_ready_i && r_o.last;

  // Outstanding count and stored lane
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= ST_IDLE;
      dst_q   <= '0;
      cnt_q   <= '0;
    end else begin
      case ({ar_fire, r_done})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
      if (ar_fire) begin
        state_q <= ST_BUSY;
        dst_q   <= dst_i;
      end else if (r_done && (cnt_q == CntW'(1))) begin
        // Last read retired, any lane may be taken next
        state_q <= ST_IDLE;
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/rd_decerr_resp.sv
// Error responder, answers each read it takes with len+1 DECERR beats of zero data
`timescale 1ns/1ps
`default_nettype none

module rd_decerr_resp (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  rd_xbar_pkg::req_ar_t ar_i,
  input  logic                 ar_valid_i,
  output logic                 ar_ready_o,
  output rd_xbar_pkg::req_r_t  r_o,
  output logic                 r_valid_o,
  input  logic                 r_ready_i
);

  typedef enum logic {
    ST_IDLE = 1'b0,
    ST_RESP = 1'b1
  } state_e;

  state_e                           state_q;
  // Captured request, beats left after the current one
  logic [rd_xbar_pkg::REQ_ID_W-1:0] id_q;
  logic [rd_xbar_pkg::LEN_W-1:0]    left_q;

  // One read at a time
  assign ar_ready_o = (state_q == ST_IDLE);

  assign r_valid_o = (state_q == ST_RESP);
  assign r_o.id    = id_q;
  assign r_o.data  = '0;
  assign r_o.resp  = rd_xbar_pkg::RESP_DECERR;
  assign r_o.last  = (left_q == '0);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= ST_IDLE;
    end else if ((state_q == ST_IDLE) && ar_valid_i) begin
      state_q <= ST_RESP;
    end else if (r_valid_o && r_ready_i && r_o.last) begin
      state_q <= ST_IDLE;
    end
  end

  // Burst bookkeeping
  always_ff @(posedge clk_i) begin
    if (ar_valid_i && ar_ready_o) begin
      id_q   <= ar_i.id;
      left_q <= ar_i.len;
    end else if (r_valid_o && r_ready_i) begin
      left_q <= left_q - 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: hdl/rd_target_mux.sv
// Per-target mux, round-robin AR arbitration with ID widening and R return by ID top bits
`timescale 1ns/1ps
`default_nettype none

module rd_target_mux (
  input  logic                                               clk_i,
  input  logic                                               arst_n_i,
  // From the requester demuxes
  input  rd_xbar_pkg::req_ar_t [rd_xbar_pkg::NUM_REQ-1:0]    req_ar_i,
  input  logic [rd_xbar_pkg::NUM_REQ-1:0]                    req_ar_valid_i,
  output logic [rd_xbar_pkg::NUM_REQ-1:0]                    req_ar_ready_o,
  output rd_xbar_pkg::req_r_t [rd_xbar_pkg::NUM_REQ-1:0]     req_r_o,
  output logic [rd_xbar_pkg::NUM_REQ-1:0]                    req_r_valid_o,
  input  logic [rd_xbar_pkg::NUM_REQ-1:0]                    req_r_ready_i,
  // Target port
  output rd_xbar_pkg::tgt_ar_t                               tgt_ar_o,
  output logic                                               tgt_ar_valid_o,
  input  logic                                               tgt_ar_ready_i,
  input  rd_xbar_pkg::tgt_r_t                                tgt_r_i,
  input  logic                                               tgt_r_valid_i,
  output logic                                               tgt_r_ready_o
);

  // Round-robin start point, lock flag and locked requester
  logic [rd_xbar_pkg::REQ_IDX_W-1:0] rr_q;
  logic                              lock_q;
  logic [rd_xbar_pkg::REQ_IDX_W-1:0] lock_idx_q;

  logic [rd_xbar_pkg::REQ_IDX_W-1:0] gnt_idx;
  logic                              gnt_valid;
  logic [31:0]                       rr_next;
  logic [rd_xbar_pkg::REQ_IDX_W-1:0] r_idx;

  // Grant
  // Held while a granted AR waits, otherwise the first valid from the pointer on
  always_comb begin
    logic [31:0] cand;
    logic        found;
    cand    = '0;
    found   = 1'b0;
    gnt_idx = rr_q;
    if (lock_q) begin
      gnt_idx = lock_idx_q;
    end else begin
      for (int k = 0; k < rd_xbar_pkg::NUM_REQ; k++) begin
        cand = (32'(rr_q) + 32'(k)) % 32'(rd_xbar_pkg::NUM_REQ);
        if (!found && req_ar_valid_i[cand[rd_xbar_pkg::REQ_IDX_W-1:0]]) begin
          found   = 1'b1;
          gnt_idx = cand[rd_xbar_pkg::REQ_IDX_W-1:0];
        end
      end
    end
  end

  assign gnt_valid = req_ar_valid_i[gnt_idx];

  // Widen the ID with the requester index
  assign tgt_ar_valid_o = gnt_valid;
  assign tgt_ar_o.id    = {gnt_idx, req_ar_i[gnt_idx].id};
  assign tgt_ar_o.addr  = req_ar_i[gnt_idx].addr;
  assign tgt_ar_o.len   = req_ar_i[gnt_idx].len;

  for (genvar i = 0; i < rd_xbar_pkg::NUM_REQ; i++) begin : gen_req
    assign req_ar_ready_o[i] = tgt_ar_ready_i && gnt_valid && (gnt_idx == i);

    // R payload to all requesters with the index stripped
    assign req_r_o[i].id    = tgt_r_i.id[rd_xbar_pkg::REQ_ID_W-1:0];
    assign req_r_o[i].data  = tgt_r_i.data;
    assign req_r_o[i].resp  = tgt_r_i.resp;
    assign req_r_o[i].last  = tgt_r_i.last;
    assign req_r_valid_o[i] = tgt_r_valid_i && (r_idx == i);
  end

  // Requester index sits in the ID top bits
  assign r_idx         = tgt_r_i.id[rd_xbar_pkg::TGT_ID_W-1 -: rd_xbar_pkg::REQ_IDX_W];
  assign tgt_r_ready_o = req_r_ready_i[r_idx];

  // Pointer moves past the winner on each transfer
  assign rr_next = (32'(gnt_idx) + 32'd1) % 32'(rd_xbar_pkg::NUM_REQ);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rr_q       <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else begin
      // Lock under back-pressure so the target sees a stable request
      lock_q     <= gnt_valid && !tgt_ar_ready_i;
      lock_idx_q <= gnt_idx;
      if (gnt_valid && tgt_ar_ready_i) begin
        rr_q <= rr_next[rd_xbar_pkg::REQ_IDX_W-1:0];
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/rd_xbar_top.sv
// Read crossbar top level, decoders, demuxes and error responders per requester, muxes per target
`timescale 1ns/1ps
`default_nettype none

module rd_xbar_top #(
  parameter int unsigned NumRules = 3,
  parameter int unsigned MaxTrans = 4
) (
  input  logic                                                 clk_i,
  input  logic                                                 arst_n_i,
  // Requester ports
  input  rd_xbar_pkg::req_ar_t [rd_xbar_pkg::NUM_REQ-1:0]      req_ar_i,
  input  logic [rd_xbar_pkg::NUM_REQ-1:0]                      req_ar_valid_i,
  output logic [rd_xbar_pkg::NUM_REQ-1:0]                      req_ar_ready_o,
  output rd_xbar_pkg::req_r_t [rd_xbar_pkg::NUM_REQ-1:0]       req_r_o,
  output logic [rd_xbar_pkg::NUM_REQ-1:0]                      req_r_valid_o,
  input  logic [rd_xbar_pkg::NUM_REQ-1:0]                      req_r_ready_i,
  // Target ports
  output rd_xbar_pkg::tgt_ar_t [rd_xbar_pkg::NUM_TGT-1:0]      tgt_ar_o,
  output logic [rd_xbar_pkg::NUM_TGT-1:0]                      tgt_ar_valid_o,
  input  logic [rd_xbar_pkg::NUM_TGT-1:0]                      tgt_ar_ready_i,
  input  rd_xbar_pkg::tgt_r_t [rd_xbar_pkg::NUM_TGT-1:0]       tgt_r_i,
  input  logic [rd_xbar_pkg::NUM_TGT-1:0]                      tgt_r_valid_i,
  output logic [rd_xbar_pkg::NUM_TGT-1:0]                      tgt_r_ready_o,
  // Global rule map and per-requester default target
  input  rd_xbar_pkg::rule_t [NumRules-1:0]                    addr_map_i,
  input  logic [rd_xbar_pkg::NUM_REQ-1:0]                      dflt_en_i,
  input  logic [rd_xbar_pkg::NUM_REQ-1:0][rd_xbar_pkg::TGT_IDX_W-1:0] dflt_tgt_i
);

  // Demux side, indexed [requester][lane]
  rd_xbar_pkg::req_ar_t [rd_xbar_pkg::NUM_REQ-1:0][rd_xbar_pkg::NUM_TGT:0] lane_ar;
  logic [rd_xbar_pkg::NUM_REQ-1:0][rd_xbar_pkg::NUM_TGT:0] lane_ar_valid, lane_ar_ready;
  rd_xbar_pkg::req_r_t  [rd_xbar_pkg::NUM_REQ-1:0][rd_xbar_pkg::NUM_TGT:0] lane_r;
  logic [rd_xbar_pkg::NUM_REQ-1:0][rd_xbar_pkg::NUM_TGT:0] lane_r_valid, lane_r_ready;

  // Mux side, indexed [target][requester]
  rd_xbar_pkg::req_ar_t [rd_xbar_pkg::NUM_TGT-1:0][rd_xbar_pkg::NUM_REQ-1:0] mux_ar;
  logic [rd_xbar_pkg::NUM_TGT-1:0][rd_xbar_pkg::NUM_REQ-1:0] mux_ar_valid, mux_ar_ready;
  rd_xbar_pkg::req_r_t  [rd_xbar_pkg::NUM_TGT-1:0][rd_xbar_pkg::NUM_REQ-1:0] mux_r;
  logic [rd_xbar_pkg::NUM_TGT-1:0][rd_xbar_pkg::NUM_REQ-1:0] mux_r_valid, mux_r_ready;

  logic [rd_xbar_pkg::NUM_REQ-1:0][rd_xbar_pkg::DST_W-1:0] dst;

  for (genvar i = 0; i < rd_xbar_pkg::NUM_REQ; i++) begin : gen_req
    rd_addr_decoder #(
      .NumRules ( NumRules )
    ) i_decoder (
      .addr_i     ( req_ar_i[i].addr ),
      .addr_map_i ( addr_map_i       ),
      .dflt_en_i  ( dflt_en_i[i]     ),
      .dflt_tgt_i ( dflt_tgt_i[i]    ),
      .dst_o      ( dst[i]           )
    );

    rd_req_demux #(
      .MaxTrans ( MaxTrans )
    ) i_demux (
      .clk_i           ( clk_i             ),
      .arst_n_i        ( arst_n_i          ),
      .ar_i            ( req_ar_i[i]       ),
      .ar_valid_i      ( req_ar_valid_i[i] ),
      .ar_ready_o      ( req_ar_ready_o[i] ),
      .dst_i           ( dst[i]            ),
      .r_o             ( req_r_o[i]        ),
      .r_valid_o       ( req_r_valid_o[i]  ),
      .r_ready_i       ( req_r_ready_i[i]  ),
      .lane_ar_o       ( lane_ar[i]        ),
      .lane_ar_valid_o ( lane_ar_valid[i]  ),
      .lane_ar_ready_i ( lane_ar_ready[i]  ),
      .lane_r_i        ( lane_r[i]         ),
      .lane_r_valid_i  ( lane_r_valid[i]   ),
      .lane_r_ready_o  ( lane_r_ready[i]   )
    );

    // Error lane ends in the requester's own responder
    rd_decerr_resp i_decerr (
      .clk_i      ( clk_i                                  ),
      .arst_n_i   ( arst_n_i                               ),
      .ar_i       ( lane_ar[i][rd_xbar_pkg::NUM_TGT]       ),
      .ar_valid_i ( lane_ar_valid[i][rd_xbar_pkg::NUM_TGT] ),
      .ar_ready_o ( lane_ar_ready[i][rd_xbar_pkg::NUM_TGT] ),
      .r_o        ( lane_r[i][rd_xbar_pkg::NUM_TGT]        ),
      .r_valid_o  ( lane_r_valid[i][rd_xbar_pkg::NUM_TGT]  ),
      .r_ready_i  ( lane_r_ready[i][rd_xbar_pkg::NUM_TGT]  )
    );

    // Crossing, target lanes swap their index order
    for (genvar j = 0; j < rd_xbar_pkg::NUM_TGT; j++) begin : gen_cross
      assign mux_ar[j][i]       = lane_ar[i][j];
      assign mux_ar_valid[j][i] = lane_ar_valid[i][j];
      assign lane_ar_ready[i][j] = mux_ar_ready[j][i];
      assign lane_r[i][j]       = mux_r[j][i];
      assign lane_r_valid[i][j] = mux_r_valid[j][i];
      assign mux_r_ready[j][i]  = lane_r_ready[i][j];
    end
  end

  for (genvar j = 0; j < rd_xbar_pkg::NUM_TGT; j++) begin : gen_tgt
    rd_target_mux i_mux (
      .clk_i          ( clk_i             ),
      .arst_n_i       ( arst_n_i          ),
      .req_ar_i       ( mux_ar[j]         ),
      .req_ar_valid_i ( mux_ar_valid[j]   ),
      .req_ar_ready_o ( mux_ar_ready[j]   ),
      .req_r_o        ( mux_r[j]          ),
      .req_r_valid_o  ( mux_r_valid[j]    ),
      .req_r_ready_i  ( mux_r_ready[j]    ),
      .tgt_ar_o       ( tgt_ar_o[j]       ),
      .tgt_ar_valid_o ( tgt_ar_valid_o[j] ),
      .tgt_ar_ready_i ( tgt_ar_ready_i[j] ),
      .tgt_r_i        ( tgt_r_i[j]        ),
      .tgt_r_valid_i  ( tgt_r_valid_i[j]  ),
      .tgt_r_ready_o  ( tgt_r_ready_o[j]  )
    );
  end

endmodule

`default_nettype wire

// File: verif/rd_xbar_checker.sv
// Protocol assertions for the read crossbar, attached to the top level by bind
`timescale 1ns/1ps
`default_nettype none

module rd_xbar_checker (
  input wire logic                                            clk_i,
  input wire logic                                            arst_n_i,
  input wire logic [rd_xbar_pkg::NUM_REQ-1:0]                 req_ar_valid_i,
  input wire logic [rd_xbar_pkg::NUM_REQ-1:0]                 req_ar_ready_i,
  input rd_xbar_pkg::req_r_t [rd_xbar_pkg::NUM_REQ-1:0]       req_r_i,
  input wire logic [rd_xbar_pkg::NUM_REQ-1:0]                 req_r_valid_i,
  input wire logic [rd_xbar_pkg::NUM_REQ-1:0]                 req_r_ready_i,
  input rd_xbar_pkg::tgt_ar_t [rd_xbar_pkg::NUM_TGT-1:0]      tgt_ar_i,
  input wire logic [rd_xbar_pkg::NUM_TGT-1:0]                 tgt_ar_valid_i,
  input wire logic [rd_xbar_pkg::NUM_TGT-1:0]                 tgt_ar_ready_i
);

  // Reads in flight per requester, seen from the requester ports
  logic [rd_xbar_pkg::NUM_REQ-1:0][7:0] open_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      open_q <= '0;
    end else begin
      for (int i = 0; i < rd_xbar_pkg::NUM_REQ; i++) begin
        open_q[i] <= open_q[i] + 8'(req_ar_valid_i[i] && req_ar_ready_i[i])
                     - 8'(req_r_valid_i[i] && req_r_ready_i[i] && req_r_i[i].last);
      end
    end
  end

  for (genvar j = 0; j < rd_xbar_pkg::NUM_TGT; j++) begin : gen_tgt
    // Request held steady while the target stalls
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
      tgt_ar_valid_i[j] && !tgt_ar_ready_i[j] |=> tgt_ar_valid_i[j] && $stable(tgt_ar_i[j]))
      else $error("target %0d AR changed under back-pressure", j);

    // ID top bit names the requester that presents this read
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
      tgt_ar_valid_i[j] |-> req_ar_valid_i[tgt_ar_i[j].id[rd_xbar_pkg::TGT_ID_W-1]])
      else $error("target %0d AR ID names an idle requester", j);

    // Transfer at the target is the granted requester's transfer
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
      tgt_ar_valid_i[j] && tgt_ar_ready_i[j]
        |-> req_ar_ready_i[tgt_ar_i[j].id[rd_xbar_pkg::TGT_ID_W-1]])
      else $error("target %0d AR taken without requester grant", j);
  end

  for (genvar i = 0; i < rd_xbar_pkg::NUM_REQ; i++) begin : gen_req
    // No answer without a read in flight
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
      req_r_valid_i[i] |-> (open_q[i] != 8'd0))
      else $error("requester %0d R valid with nothing outstanding", i);
  end

endmodule

bind rd_xbar_top rd_xbar_checker i_checker (
  .clk_i          ( clk_i          ),
  .arst_n_i       ( arst_n_i       ),
  .req_ar_valid_i ( req_ar_valid_i ),
  .req_ar_ready_i ( req_ar_ready_o ),
  .req_r_i        ( req_r_o        ),
  .req_r_valid_i  ( req_r_valid_o  ),
  .req_r_ready_i  ( req_r_ready_i  ),
  .tgt_ar_i       ( tgt_ar_o       ),
  .tgt_ar_valid_i ( tgt_ar_valid_o ),
  .tgt_ar_ready_i ( tgt_ar_ready_i )
);

`default_nettype wire

// File: verif/rd_xbar_tb.sv
// Self-checking testbench for the read crossbar that runs as top and reads the pattern file from the root
`timescale 1ns/1ps
`default_nettype none

module rd_xbar_tb;

  localparam int unsigned NumRules = 3;
  localparam int unsigned MaxTrans = 4;
  localparam int unsigned MaxPat   = 64;
  // Columns per read are req, id, addr, len, dflt_en and exp_dst
  localparam int unsigned PatCols  = 6;

  logic clk_i;
  logic arst_n_i;

  rd_xbar_pkg::req_ar_t [rd_xbar_pkg::NUM_REQ-1:0] req_ar;
  logic [rd_xbar_pkg::NUM_REQ-1:0]                 req_ar_valid, req_ar_ready;
  rd_xbar_pkg::req_r_t  [rd_xbar_pkg::NUM_REQ-1:0] req_r;
  logic [rd_xbar_pkg::NUM_REQ-1:0]                 req_r_valid, req_r_ready;
  rd_xbar_pkg::tgt_ar_t [rd_xbar_pkg::NUM_TGT-1:0] tgt_ar;
  logic [rd_xbar_pkg::NUM_TGT-1:0]                 tgt_ar_valid, tgt_ar_ready;
  rd_xbar_pkg::tgt_r_t  [rd_xbar_pkg::NUM_TGT-1:0] tgt_r;
  logic [rd_xbar_pkg::NUM_TGT-1:0]                 tgt_r_valid, tgt_r_ready;
  rd_xbar_pkg::rule_t   [NumRules-1:0]             addr_map;
  logic [rd_xbar_pkg::NUM_REQ-1:0]                 dflt_en;
  logic [rd_xbar_pkg::NUM_REQ-1:0][rd_xbar_pkg::TGT_IDX_W-1:0] dflt_tgt;

  // Pattern store and progress
  logic [31:0] pat_mem [MaxPat*PatCols];
  int          num_pat;
  int          total_beats;
  int          rx_beats;
  // Current pattern and AR shown per requester
  int          ptr [rd_xbar_pkg::NUM_REQ];
  logic        busy [rd_xbar_pkg::NUM_REQ];
  rd_xbar_pkg::req_r_t  exp_q [rd_xbar_pkg::NUM_REQ][$];
  // Accepted reads and current burst of each target model
  rd_xbar_pkg::tgt_ar_t pend_q [rd_xbar_pkg::NUM_TGT][$];
  logic        r_act [rd_xbar_pkg::NUM_TGT];
  int          beat_cnt [rd_xbar_pkg::NUM_TGT];
  int          gap [rd_xbar_pkg::NUM_TGT];

  rd_xbar_top #(
    .NumRules ( NumRules ),
    .MaxTrans ( MaxTrans )
  ) dut (
    .clk_i          ( clk_i        ),
    .arst_n_i       ( arst_n_i     ),
    .req_ar_i       ( req_ar       ),
    .req_ar_valid_i ( req_ar_valid ),
    .req_ar_ready_o ( req_ar_ready ),
    .req_r_o        ( req_r        ),
    .req_r_valid_o  ( req_r_valid  ),
    .req_r_ready_i  ( req_r_ready  ),
    .tgt_ar_o       ( tgt_ar       ),
    .tgt_ar_valid_o ( tgt_ar_valid ),
    .tgt_ar_ready_i ( tgt_ar_ready ),
    .tgt_r_i        ( tgt_r        ),
    .tgt_r_valid_i  ( tgt_r_valid  ),
    .tgt_r_ready_o  ( tgt_r_ready  ),
    .addr_map_i     ( addr_map     ),
    .dflt_en_i      ( dflt_en      ),
    .dflt_tgt_i     ( dflt_tgt     )
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // Target memory holds the word address with a per-target tag
  function automatic logic [31:0] beat_data(input logic [31:0] addr, input int beat,
                                            input int tgt);
    return (addr + 32'(4 * beat)) ^ (32'(tgt) << 28);
  endfunction

  // Next pattern index of one requester or num_pat when none is left
  function automatic int next_read(input int r, input int from);
    int p;
    p = from;
    while ((p < num_pat) && (pat_mem[p*PatCols] != 32'(r))) begin
      p++;
    end
    return p;
  endfunction

  task automatic stop_on_failure();
    $display("TEST RESULT: FAIL");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    assert (got === exp) else begin
      $display("ERROR t=%0t %s got=0x%0h exp=0x%0h", $time, name, got, exp);
      stop_on_failure();
    end
  endtask

  // Same-cycle pass-through to the decoded target with the requester index on top of the ID
  task automatic check_forward(input int r, input int p);
    int                   dst;
    rd_xbar_pkg::tgt_ar_t exp_ar;
    dst = int'(pat_mem[p*PatCols+5]);
    if (dst < int'(rd_xbar_pkg::NUM_TGT)) begin
      exp_ar.id   = {1'(r), pat_mem[p*PatCols+1][rd_xbar_pkg::REQ_ID_W-1:0]};
      exp_ar.addr = pat_mem[p*PatCols+2];
      exp_ar.len  = pat_mem[p*PatCols+3][rd_xbar_pkg::LEN_W-1:0];
      check_value($sformatf("tgt_ar_valid_o[%0d]", dst),
                  64'(tgt_ar_valid[dst] && tgt_ar_ready[dst]), 64'd1);
      check_value($sformatf("tgt_ar_o[%0d]", dst), 64'(tgt_ar[dst]), 64'(exp_ar));
    end
  endtask

  // Expected burst from the pattern where the error lane gives zero data
  task automatic expect_burst(input int r, input int p);
    rd_xbar_pkg::req_r_t e;
    int                  dst;
    int                  len;
    dst = int'(pat_mem[p*PatCols+5]);
    len = int'(pat_mem[p*PatCols+3]);
    for (int b = 0; b <= len; b++) begin
      e.id   = pat_mem[p*PatCols+1][rd_xbar_pkg::REQ_ID_W-1:0];
      e.last = (b == len);
      if (dst >= int'(rd_xbar_pkg::NUM_TGT)) begin
        e.data = '0;
        e.resp = rd_xbar_pkg::RESP_DECERR;
      end else begin
        e.data = beat_data(pat_mem[p*PatCols+2], b, dst);
        e.resp = rd_xbar_pkg::RESP_OKAY;
      end
      exp_q[r].push_back(e);
    end
  endtask

  // All DUT inputs from the current model state on the falling edge
  task automatic drive_inputs();
    int base;
    for (int r = 0; r < rd_xbar_pkg::NUM_REQ; r++) begin
      if (!busy[r] && (ptr[r] < num_pat) && (($urandom % 4) != 0)) begin
        base           = ptr[r] * PatCols;
        req_ar[r].id   = pat_mem[base+1][rd_xbar_pkg::REQ_ID_W-1:0];
        req_ar[r].addr = pat_mem[base+2];
        req_ar[r].len  = pat_mem[base+3][rd_xbar_pkg::LEN_W-1:0];
        dflt_en[r]     = pat_mem[base+4][0];
        busy[r]        = 1'b1;
      end
      req_ar_valid[r] = busy[r];
      req_r_ready[r]  = ($urandom % 4) != 0;
    end
    for (int t = 0; t < rd_xbar_pkg::NUM_TGT; t++) begin
      tgt_ar_ready[t] = ($urandom % 4) != 0;
      if (!r_act[t] && (pend_q[t].size() != 0)) begin
        if (gap[t] == 0) begin
          r_act[t]    = 1'b1;
          beat_cnt[t] = 0;
        end else begin
          gap[t]--;
        end
      end
      tgt_r_valid[t] = r_act[t];
      if (r_act[t]) begin
        tgt_r[t].id   = pend_q[t][0].id;
        tgt_r[t].data = beat_data(pend_q[t][0].addr, beat_cnt[t], t);
        tgt_r[t].resp = rd_xbar_pkg::RESP_OKAY;
        tgt_r[t].last = (beat_cnt[t] == int'(pend_q[t][0].len));
      end
    end
  endtask

  // Transfers that the next rising edge will take as seen in the low phase
  task automatic sample_outputs();
    rd_xbar_pkg::req_r_t e;
    for (int r = 0; r < rd_xbar_pkg::NUM_REQ; r++) begin
      if (req_ar_valid[r] && req_ar_ready[r]) begin
        check_forward(r, ptr[r]);
        expect_burst(r, ptr[r]);
        busy[r] = 1'b0;
        ptr[r]  = next_read(r, ptr[r] + 1);
      end
      if (req_r_valid[r] && req_r_ready[r]) begin
        assert (exp_q[r].size() != 0) else begin
          $display("Requester %0d got a response beat it never asked for", r);
          stop_on_failure();
        end
        e = exp_q[r].pop_front();
        check_value($sformatf("req_r_o[%0d]", r), 64'(req_r[r]), 64'(e));
        rx_beats++;
      end
    end
    for (int t = 0; t < rd_xbar_pkg::NUM_TGT; t++) begin
      if (tgt_ar_valid[t] && tgt_ar_ready[t]) begin
        pend_q[t].push_back(tgt_ar[t]);
      end
      if (tgt_r_valid[t] && tgt_r_ready[t]) begin
        if (beat_cnt[t] == int'(pend_q[t][0].len)) begin
          void'(pend_q[t].pop_front());
          r_act[t] = 1'b0;
          gap[t]   = $urandom % 3;
        end else begin
          beat_cnt[t]++;
        end
      end
    end
  endtask

  // Watchdog allows 64 cycles per read
  initial begin
    wait (num_pat > 0);
    repeat (8 + num_pat * 64) @(posedge clk_i);
    $display("Watchdog expired with %0d of %0d beats received", rx_beats, total_beats);
    $display("TEST RESULT: FAIL");
    $fatal(1, "Run stopped by the watchdog");
  end

  initial begin
    int cnt;
    int beats;
    void'($urandom(48592));
    arst_n_i     = 1'b0;
    req_ar       = '0;
    req_ar_valid = '0;
    req_r_ready  = '0;
    tgt_ar_ready = '0;
    tgt_r        = '0;
    tgt_r_valid  = '0;
    dflt_en      = '0;
    dflt_tgt[0]  = 1'b1;
    dflt_tgt[1]  = 1'b0;
    // Rule 2 sits inside rule 1 and wins there
    addr_map[0]  = '{tgt_idx: 1'b0, start_addr: 32'h0000_0000, end_addr: 32'h1000_0000};
    addr_map[1]  = '{tgt_idx: 1'b1, start_addr: 32'h1000_0000, end_addr: 32'h2000_0000};
    addr_map[2]  = '{tgt_idx: 1'b0, start_addr: 32'h1800_0000, end_addr: 32'h1900_0000};
    rx_beats     = 0;
    for (int t = 0; t < rd_xbar_pkg::NUM_TGT; t++) begin
      r_act[t]    = 1'b0;
      beat_cnt[t] = 0;
      gap[t]      = 0;
    end
    // Unused entries hold the inverted index and never a requester number
    for (int i = 0; i < MaxPat * PatCols; i++) begin
      pat_mem[i] = ~32'(i);
    end
    $readmemh("verif/rd_xbar_patterns.txt", pat_mem);
    cnt   = 0;
    beats = 0;
    while ((cnt < MaxPat) && (pat_mem[cnt*PatCols] < 32'(rd_xbar_pkg::NUM_REQ))) begin
      beats += int'(pat_mem[cnt*PatCols+3]) + 1;
      cnt++;
    end
    assert (cnt > 0) else begin
      $display("No reads found in the pattern file");
      stop_on_failure();
    end
    total_beats = beats;
    num_pat     = cnt;
    for (int r = 0; r < rd_xbar_pkg::NUM_REQ; r++) begin
      busy[r] = 1'b0;
      ptr[r]  = next_read(r, 0);
    end
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    arst_n_i = 1'b1;
    while (rx_beats < total_beats) begin
      @(negedge clk_i);
      drive_inputs();
      #1;
      sample_outputs();
    end
    // Nothing left over on either side
    for (int r = 0; r < rd_xbar_pkg::NUM_REQ; r++) begin
      check_value($sformatf("expected beats left for requester %0d", r),
                  64'(exp_q[r].size()), 64'd0);
    end
    for (int t = 0; t < rd_xbar_pkg::NUM_TGT; t++) begin
      check_value($sformatf("reads left at target %0d", t), 64'(pend_q[t].size()), 64'd0);
    end
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: rd_xbar.f
hdl/rd_xbar_pkg.sv
hdl/rd_addr_decoder.sv
hdl/rd_req_demux.sv
hdl/rd_decerr_resp.sv
hdl/rd_target_mux.sv
hdl/rd_xbar_top.sv
verif/rd_xbar_checker.sv
verif/rd_xbar_tb.sv

// File: Makefile
# Verilator build and run of the read crossbar testbench

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module rd_xbar_tb \
	  -f rd_xbar.f -Mdir obj_dir -o rd_xbar_sim
	@out="$$(./obj_dir/rd_xbar_sim)"; echo "$$out"; \
	  echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf obj_dir

// File: verif/rd_xbar_patterns.txt
// req id addr len dflt_en exp_dst in hex, one read per line
// exp_dst 0 or 1 is a target, 2 the error responder; default target is 1 for req 0, 0 for req 1
0 1 00000100 0 0 0
1 2 10000200 1 0 1
0 3 10000040 3 0 1
1 4 00000080 2 0 0
0 5 18800000 1 0 0
1 6 18fffffc 0 0 0
0 7 30000000 2 0 2
1 8 30000010 0 0 2
0 9 30000020 1 1 1
1 a 30000030 1 1 0
0 b 20000000 0 0 2
1 c 1ffffff0 3 0 1
0 d 0ffffffc 0 0 0
1 e 19000000 2 0 1
0 f 17fffff0 1 0 1
1 0 00001000 f 0 0
0 2 10000800 7 0 1
1 3 40000000 3 0 2
0 4 00000400 2 0 0
1 5 10001000 1 0 1
0 6 18000000 0 0 0
1 7 00002000 1 0 0
